// File: all.f
verilog/hci_pkg.sv
verilog/hci_queue.sv
verilog/hci_cmd_assembler.sv
verilog/hci_csr.sv
verilog/hci_top.sv
tests/hci_tb.sv

// File: run.sh
#!/bin/sh
# Build the HCI testbench with Verilator, run it and look for the pass message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module hci_tb -f all.f -o hci_sim \
  && ./obj_dir/hci_sim 2>&1 | tee sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tests/hci_tb.sv
/* HCI testbench: drives the CPU and controller sides of hci_top and checks
   every response and the outbound queue heads against a queue model */
`timescale 1ns/1ps
`default_nettype none

module hci_tb
  import hci_pkg::*;
();

  localparam int unsigned ClkPeriod      = 100;
  localparam int unsigned NumOps         = 150;  // Upper bound on the operations below
  localparam int unsigned WatchdogCycles = NumOps * 10 + 1000;

  logic       clk_i;
  logic       rst_ni;
  cpu_req_t   cpu_req;
  cpu_rsp_t   cpu_rsp;
  logic       cmd_pop;
  ctrl_pop_t  cmd_out;
  logic       tx_pop;
  ctrl_pop_t  tx_out;
  ctrl_push_t rx_in;
  logic       rx_full;
  ctrl_push_t resp_in;
  logic       resp_full;
  logic       settled;  // No DUT update in flight, heads can be compared

  // Reference model state
  logic [CmdWidth-1:0]  cmd_mq [$];
  logic [DataWidth-1:0] tx_mq [$];
  logic [DataWidth-1:0] rx_mq [$];
  logic [DataWidth-1:0] resp_mq [$];
  cpu_rsp_t             exp_rsp_q [$];
  int                   thld [NumQueues] = '{1, 1, 1, 1};
  logic                 cmd_half;
  logic [DataWidth-1:0] cmd_low;
  logic [31:0]          lfsr = 32'h5e52b724;

  hci_top dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cpu_req_i   (cpu_req),
    .cpu_rsp_o   (cpu_rsp),
    .cmd_pop_i   (cmd_pop),
    .cmd_o       (cmd_out),
    .tx_pop_i    (tx_pop),
    .tx_o        (tx_out),
    .rx_i        (rx_in),
    .rx_full_o   (rx_full),
    .resp_i      (resp_in),
    .resp_full_o (resp_full)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0d ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic abort_run(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [DataWidth-1:0] next_random(input int unsigned nbits);
    logic [DataWidth-1:0] value;
    logic                 lsb;
    value = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr ^= 32'h8020_0003;
      value = {value[DataWidth-2:0], lsb};
    end
    return value;
  endfunction

  function automatic int clamped(input int value);
    return (value > int'(QueueDepth) - 1) ? int'(QueueDepth) - 1 : value;
  endfunction

  // Empty bits low, threshold-reached bits above them
  function automatic logic [DataWidth-1:0] status_word();
    logic [DataWidth-1:0] word;
    word = '0;
    word[QCmd]  = (cmd_mq.size() == 0);
    word[QRx]   = (rx_mq.size() == 0);
    word[QTx]   = (tx_mq.size() == 0);
    word[QResp] = (resp_mq.size() == 0);
    word[NumQueues + int'(QCmd)]  = (int'(QueueDepth) - cmd_mq.size()) >= thld[QCmd];
    word[NumQueues + int'(QTx)]   = (int'(QueueDepth) - tx_mq.size()) >= thld[QTx];
    word[NumQueues + int'(QRx)]   = rx_mq.size() >= thld[QRx];
    word[NumQueues + int'(QResp)] = resp_mq.size() >= thld[QResp];
    return word;
  endfunction

  // Expected response of one CPU access, model updated as a side effect
  function automatic cpu_rsp_t expect_access(input logic wr, input logic [AddrWidth-1:0] addr,
                                             input logic [DataWidth-1:0] data);
    cpu_rsp_t rsp;
    rsp        = '0;
    rsp.rd_ack = ~wr;
    rsp.wr_ack = wr;
    case (addr)
      RegResetCtrl: begin
        if (wr) begin
          if (data[QCmd]) begin
            cmd_mq.delete();
            cmd_half = 1'b0;  // Half command is lost as well
          end
          if (data[QRx]) rx_mq.delete();
          if (data[QTx]) tx_mq.delete();
          if (data[QResp]) resp_mq.delete();
        end
      end
      RegQueueThld: begin
        if (wr) begin
          thld[QCmd]  = clamped(int'(data[7:0]));
          thld[QResp] = clamped(int'(data[15:8]));
        end else begin
          rsp.rdata[7:0]  = 8'(thld[QCmd]);
          rsp.rdata[15:8] = 8'(thld[QResp]);
        end
      end
      RegDataThld: begin
        if (wr) begin
          thld[QRx] = clamped(int'(data[2:0]));
          thld[QTx] = clamped(int'(data[10:8]));
        end else begin
          rsp.rdata[2:0]  = 3'(thld[QRx]);
          rsp.rdata[10:8] = 3'(thld[QTx]);
        end
      end
      RegCmdPort: begin
        if (!wr || cmd_mq.size() == int'(QueueDepth)) begin
          rsp.err = 1'b1;
        end else if (cmd_half) begin
          cmd_mq.push_back({data, cmd_low});
          cmd_half = 1'b0;
        end else begin
          cmd_low  = data;
          cmd_half = 1'b1;
        end
      end
      RegXferPort: begin
        if (wr) begin
          if (tx_mq.size() == int'(QueueDepth)) rsp.err = 1'b1;
          else tx_mq.push_back(data);
        end else if (rx_mq.size() == 0) begin
          rsp.err = 1'b1;
        end else begin
          rsp.rdata = rx_mq.pop_front();
        end
      end
      RegRespPort: begin
        if (wr || resp_mq.size() == 0) rsp.err = 1'b1;
        else rsp.rdata = resp_mq.pop_front();
      end
      RegQueueStatus: begin
        if (wr) rsp.err = 1'b1;
        else rsp.rdata = status_word();
      end
      default: rsp.err = 1'b1;
    endcase
    return rsp;
  endfunction

  // One CPU access, then enough idle cycles for the pushes behind it to land
  task automatic cpu_access(input logic wr, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data);
    settled = 1'b0;
    exp_rsp_q.push_back(expect_access(wr, addr, data));
    cpu_req = '{req: 1'b1, is_wr: wr, addr: addr, wdata: data};
    @(posedge clk_i);
    #1;
    cpu_req = '0;
    repeat (2) @(posedge clk_i);
    #1;
    settled = 1'b1;  // Command push lands three cycles after the access
    @(posedge clk_i);
    #1;
    assert (exp_rsp_q.size() == 0) else abort_run("a CPU access got no acknowledge");
  endtask

  task automatic push_inbound(input logic do_rx, input logic do_resp);
    logic [DataWidth-1:0] rx_word;
    logic [DataWidth-1:0] resp_word;
    rx_word   = next_random(32);
    resp_word = next_random(32);
    settled   = 1'b0;
    rx_in     = '{push: do_rx, data: rx_word};
    resp_in   = '{push: do_resp, data: resp_word};
    if (do_rx) rx_mq.push_back(rx_word);
    if (do_resp) resp_mq.push_back(resp_word);
    @(posedge clk_i);
    #1;
    rx_in.push   = 1'b0;
    resp_in.push = 1'b0;
    settled      = 1'b1;
  endtask

  task automatic pop_outbound(input logic do_cmd, input logic do_tx);
    settled = 1'b0;
    cmd_pop = do_cmd;
    tx_pop  = do_tx;
    if (do_cmd) cmd_mq.delete(0);
    if (do_tx) tx_mq.delete(0);
    @(posedge clk_i);
    #1;
    cmd_pop = 1'b0;
    tx_pop  = 1'b0;
    settled = 1'b1;
  endtask

  task automatic idle(input int unsigned cycles);
    repeat (cycles) @(posedge clk_i);
    #1;
  endtask

  task automatic check_response();
    cpu_rsp_t want;
    if (cpu_rsp.rd_ack || cpu_rsp.wr_ack) begin
      assert (exp_rsp_q.size() > 0) else abort_run("acknowledge without a CPU access");
      want = exp_rsp_q.pop_front();
      assert (cpu_rsp == want)
        else report_mismatch($sformatf("cpu response %h, expected %h", cpu_rsp, want));
    end
  endtask

  task automatic check_outputs();
    assert (cmd_out.valid == (cmd_mq.size() != 0))
      else report_mismatch($sformatf("cmd_o valid is %b", cmd_out.valid));
    if (cmd_mq.size() != 0)
      assert (cmd_out.data == cmd_mq[0])
        else report_mismatch($sformatf("cmd_o %h, expected %h", cmd_out.data, cmd_mq[0]));
    assert (tx_out.valid == (tx_mq.size() != 0))
      else report_mismatch($sformatf("tx_o valid is %b", tx_out.valid));
    if (tx_mq.size() != 0)
      assert (tx_out.data == {32'b0, tx_mq[0]})
        else report_mismatch($sformatf("tx_o %h, expected %h", tx_out.data, tx_mq[0]));
    assert (rx_full == (rx_mq.size() == int'(QueueDepth))) else report_mismatch("rx_full_o");
    assert (resp_full == (resp_mq.size() == int'(QueueDepth)))
      else report_mismatch("resp_full_o");
  endtask

  // Compare process, outputs are stable at the falling edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        check_response();
        if (settled) check_outputs();
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    abort_run("watchdog timeout, the run did not finish in time");
  end

  initial begin
    logic [1:0] pick;
    int         n;
    rst_ni   = 1'b0;
    cpu_req  = '0;
    cmd_pop  = 1'b0;
    tx_pop   = 1'b0;
    rx_in    = '0;
    resp_in  = '0;
    settled  = 1'b0;
    cmd_half = 1'b0;
    cmd_low  = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    assert (cpu_rsp == '0 && !cmd_out.valid && !tx_out.valid)
      else report_mismatch("outputs not idle after reset");
    settled = 1'b1;
    idle(2);

    // Thresholds start at 1 and clamp at depth - 1
    cpu_access(1'b0, RegQueueThld, '0);
    cpu_access(1'b0, RegDataThld, '0);
    cpu_access(1'b0, RegQueueStatus, '0);
    cpu_access(1'b1, RegQueueThld, 32'h0000_c8ff);
    cpu_access(1'b0, RegQueueThld, '0);
    cpu_access(1'b1, RegDataThld, next_random(32));
    cpu_access(1'b0, RegDataThld, '0);
    cpu_access(1'b1, RegQueueThld, 32'h0000_0305);  // Response 3, command 5
    cpu_access(1'b1, RegDataThld, 32'h0000_0402);   // TX 4, RX 2

    // Commands, first dword in the low half
    for (n = 0; n < 4; n++) begin
      cpu_access(1'b1, RegCmdPort, next_random(32));
      cpu_access(1'b1, RegCmdPort, next_random(32));
      cpu_access(1'b0, RegQueueStatus, '0);
    end
    idle(2);
    while (cmd_mq.size() > 0) begin
      pop_outbound(1'b1, 1'b0);
      idle(1);
    end

    // TX fills up, the last write is dropped
    for (n = 0; n <= int'(QueueDepth); n++) begin
      cpu_access(1'b1, RegXferPort, next_random(32));
      cpu_access(1'b0, RegQueueStatus, '0);
    end
    while (tx_mq.size() > 0) begin
      pop_outbound(1'b0, 1'b1);
      idle(1);
    end

    // Random controller pushes read back in order
    for (n = 0; n < 6; n++) begin
      pick = 2'(next_random(2));
      push_inbound(pick[0], pick[1]);
      cpu_access(1'b0, RegQueueStatus, '0);
    end
    while (rx_mq.size() > 0 || resp_mq.size() > 0) begin
      if (rx_mq.size() > 0) cpu_access(1'b0, RegXferPort, '0);
      if (resp_mq.size() > 0) cpu_access(1'b0, RegRespPort, '0);
    end
    cpu_access(1'b0, RegXferPort, '0);  // Empty reads
    cpu_access(1'b0, RegRespPort, '0);

    // Inbound queues fill up to full and drain in order
    while (rx_mq.size() < int'(QueueDepth)) begin
      push_inbound(1'b1, 1'b1);
    end
    cpu_access(1'b0, RegQueueStatus, '0);
    while (rx_mq.size() > 0) begin
      cpu_access(1'b0, RegXferPort, '0);
      cpu_access(1'b0, RegRespPort, '0);
    end

    // Errors leave the queues alone
    push_inbound(1'b1, 1'b1);
    cpu_access(1'b0, 5'h1c, '0);
    cpu_access(1'b1, 5'h02, next_random(32));
    cpu_access(1'b1, RegRespPort, next_random(32));
    cpu_access(1'b1, RegQueueStatus, next_random(32));
    cpu_access(1'b0, RegCmdPort, '0);
    cpu_access(1'b0, RegXferPort, '0);
    cpu_access(1'b0, RegRespPort, '0);

    // Queue reset with data everywhere and a half command
    cpu_access(1'b1, RegCmdPort, next_random(32));
    cpu_access(1'b1, RegCmdPort, next_random(32));
    cpu_access(1'b1, RegCmdPort, next_random(32));
    for (n = 0; n < 3; n++) begin
      cpu_access(1'b1, RegXferPort, next_random(32));
    end
    push_inbound(1'b1, 1'b1);
    push_inbound(1'b1, 1'b1);
    cpu_access(1'b0, RegQueueStatus, '0);
    cpu_access(1'b1, RegResetCtrl, 32'h0000_000f);
    cpu_access(1'b0, RegResetCtrl, '0);
    cpu_access(1'b0, RegQueueStatus, '0);
    cpu_access(1'b1, RegCmdPort, next_random(32));
    cpu_access(1'b1, RegCmdPort, next_random(32));
    idle(2);
    pop_outbound(1'b1, 1'b0);
    idle(2);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/hci_cmd_assembler.sv
/* HCI command assembler: joins two COMMAND_PORT dwords into one 64-bit
   command and pushes it to the command queue */
`timescale 1ns/1ps
`default_nettype none

module hci_cmd_assembler
  import hci_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 dword_i,
  input  logic [DataWidth-1:0] dword_data_i,
  output logic                 push_o,
  output logic [CmdWidth-1:0]  cmd_o
);

  logic                 half_q;  // First dword already held
  logic [DataWidth-1:0] low_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q <= 1'b0;
      push_o <= 1'b0;
    end else begin
      push_o <= dword_i & half_q & ~flush_i;
      if (flush_i) begin
        half_q <= 1'b0;  // Drop a half-done command
      end else if (dword_i) begin
        half_q <= ~half_q;
      end
    end
  end

  // First dword goes to the low half
  always_ff @(posedge clk_i) begin
    if (dword_i && !half_q) begin
      low_q <= dword_data_i;
    end
    if (dword_i && half_q) begin
      cmd_o <= {dword_data_i, low_q};
    end
  end

endmodule

`default_nettype wire

// File: verilog/hci_csr.sv
/* HCI register block: decodes CPU accesses, keeps queue reset control and
   thresholds, reports status and routes the PIO ports to the queues */
`timescale 1ns/1ps
`default_nettype none

module hci_csr
  import hci_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  cpu_req_t                             cpu_req_i,
  output cpu_rsp_t                             cpu_rsp_o,
  input  logic [NumQueues-1:0]                 q_empty_i,
  input  logic [NumQueues-1:0]                 q_full_i,
  input  logic [NumQueues-1:0][LevelWidth-1:0] q_level_i,
  input  logic [NumQueues-1:0][CmdWidth-1:0]   q_head_i,
  output logic [NumQueues-1:0]                 q_push_o,
  output logic [NumQueues-1:0][DataWidth-1:0]  q_wdata_o,
  output logic [NumQueues-1:0]                 q_pop_o,
  output logic [NumQueues-1:0]                 q_flush_o,
  output logic                                 cmd_dword_o,
  output logic [DataWidth-1:0]                 cmd_dword_data_o,
  input  logic                                 cmd_full_i
);

  logic                                rd_req;
  logic                                wr_req;
  logic [NumQueues-1:0]                rst_bits_q;
  logic [NumQueues-1:0]                rst_set;
  logic [NumQueues-1:0][ThldWidth-1:0] thld_q;
  logic [NumQueues-1:0]                thld_hit;
  logic                                qthld_we;
  logic                                dthld_we;
  logic                                err_d;
  logic [DataWidth-1:0]                rdata_d;
  logic [DataWidth-1:0]                wdata_q;
  logic                                tx_push_d;
  logic                                tx_push_q;
  logic                                dword_d;
  logic                                dword_d2_q;  // Strobe now inside the assembler
  logic [LevelWidth:0]                 tx_fill;
  logic [LevelWidth:0]                 cmd_fill;
  logic                                tx_room;
  logic                                cmd_room;

  function automatic logic [ThldWidth-1:0] clamp_thld(logic [7:0] value);
    if (value > 8'(QueueDepth - 1)) begin
      return ThldWidth'(QueueDepth - 1);
    end
    return value[ThldWidth-1:0];
  endfunction

  assign rd_req = cpu_req_i.req & ~cpu_req_i.is_wr;
  assign wr_req = cpu_req_i.req & cpu_req_i.is_wr;

  // Room checks count pushes still in flight toward the queue
  assign tx_fill  = {1'b0, q_level_i[QTx]} + {{LevelWidth{1'b0}}, tx_push_q};
  assign cmd_fill = {1'b0, q_level_i[QCmd]} + {{LevelWidth{1'b0}}, cmd_dword_o}
                  + {{LevelWidth{1'b0}}, dword_d2_q};  // Counts first dwords too
  assign tx_room  = ~q_full_i[QTx] & (tx_fill < {1'b0, LevelWidth'(QueueDepth)});
  assign cmd_room = ~cmd_full_i & (cmd_fill < {1'b0, LevelWidth'(QueueDepth)});

  // Free entries for the outbound queues, occupancy for the inbound ones
  always_comb begin
    thld_hit[QCmd]  = (LevelWidth'(QueueDepth) - q_level_i[QCmd]) >= LevelWidth'(thld_q[QCmd]);
    thld_hit[QTx]   = (LevelWidth'(QueueDepth) - q_level_i[QTx]) >= LevelWidth'(thld_q[QTx]);
    thld_hit[QRx]   = q_level_i[QRx] >= LevelWidth'(thld_q[QRx]);
    thld_hit[QResp] = q_level_i[QResp] >= LevelWidth'(thld_q[QResp]);
  end

  always_comb begin
    rdata_d   = '0;
    err_d     = 1'b0;
    rst_set   = '0;
    qthld_we  = 1'b0;
    dthld_we  = 1'b0;
    tx_push_d = 1'b0;
    dword_d   = 1'b0;
    q_pop_o   = '0;
    if (cpu_req_i.req) begin
      case (cpu_req_i.addr)
        RegResetCtrl: begin
          if (cpu_req_i.is_wr) begin
            rst_set = cpu_req_i.wdata[NumQueues-1:0];  // Zeros have no effect
          end else begin
            rdata_d = DataWidth'(rst_bits_q);
          end
        end
        RegQueueThld: begin
          if (cpu_req_i.is_wr) begin
            qthld_we = 1'b1;
          end else begin
            rdata_d[7:0]  = 8'(thld_q[QCmd]);
            rdata_d[15:8] = 8'(thld_q[QResp]);
          end
        end
        RegDataThld: begin
          if (cpu_req_i.is_wr) begin
            dthld_we = 1'b1;
          end else begin
            rdata_d[ThldWidth-1:0] = thld_q[QRx];
            rdata_d[8+:ThldWidth]  = thld_q[QTx];
          end
        end
        RegCmdPort: begin
          // Write-only port
          if (cpu_req_i.is_wr && !rst_bits_q[QCmd] && cmd_room) begin
            dword_d = 1'b1;
          end else begin
            err_d = 1'b1;
          end
        end
        RegXferPort: begin
          if (cpu_req_i.is_wr) begin
            if (!rst_bits_q[QTx] && tx_room) begin
              tx_push_d = 1'b1;
            end else begin
              err_d = 1'b1;  // Dropped, no stall
            end
          end else if (q_empty_i[QRx]) begin
            err_d = 1'b1;
          end else begin
            q_pop_o[QRx] = 1'b1;
            rdata_d      = q_head_i[QRx][DataWidth-1:0];
          end
        end
        RegRespPort: begin
          if (cpu_req_i.is_wr || q_empty_i[QResp]) begin
            err_d = 1'b1;
          end else begin
            q_pop_o[QResp] = 1'b1;
            rdata_d        = q_head_i[QResp][DataWidth-1:0];
          end
        end
        RegQueueStatus: begin
          if (cpu_req_i.is_wr) begin
            err_d = 1'b1;  // Read-only
          end else begin
            rdata_d = DataWidth'({thld_hit, q_empty_i});
          end
        end
        default: err_d = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cpu_rsp_o   <= '0;
      tx_push_q   <= 1'b0;
      cmd_dword_o <= 1'b0;
      dword_d2_q  <= 1'b0;
      rst_bits_q  <= '0;
    end else begin
      cpu_rsp_o.rd_ack <= rd_req;
      cpu_rsp_o.wr_ack <= wr_req;
      cpu_rsp_o.err    <= err_d;
      cpu_rsp_o.rdata  <= rdata_d;
      tx_push_q        <= tx_push_d;
      cmd_dword_o      <= dword_d;
      dword_d2_q       <= cmd_dword_o;
      // A set bit drops the cycle after its queue reports empty
      rst_bits_q <= (rst_bits_q & ~q_empty_i) | rst_set;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_q <= {NumQueues{ThldWidth'(1)}};
    end else begin
      if (qthld_we) begin
        thld_q[QCmd]  <= clamp_thld(cpu_req_i.wdata[7:0]);
        thld_q[QResp] <= clamp_thld(cpu_req_i.wdata[15:8]);
      end
      if (dthld_we) begin
        thld_q[QRx] <= clamp_thld(8'(cpu_req_i.wdata[2:0]));
        thld_q[QTx] <= clamp_thld(8'(cpu_req_i.wdata[10:8]));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_req) begin
      wdata_q <= cpu_req_i.wdata;
    end
  end

  // Only the TX queue is pushed from the CPU side
  always_comb begin
    q_push_o      = '0;
    q_push_o[QTx] = tx_push_q;
  end

  assign q_wdata_o        = {NumQueues{wdata_q}};
  assign q_flush_o        = rst_bits_q;
  assign cmd_dword_data_o = wdata_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cpu_rsp_o.rd_ack || cpu_rsp_o.wr_ack) |-> $past(cpu_req_i.req))
    else $error("ack without request");

endmodule

`default_nettype wire

// File: verilog/hci_pkg.sv
/* HCI shared definitions: register map, queue geometry, queue indices and the
   CPU and controller-side signal bundles */
`default_nettype none

package hci_pkg;

  // CPU bus geometry
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 5;

  // One command is two dwords written back to back
  localparam int unsigned CmdWidth = 2 * DataWidth;

  // Queue geometry, shared by all four queues
  localparam int unsigned QueueDepth = 8;
  localparam int unsigned LevelWidth = $clog2(QueueDepth + 1);  // Holds 0 to QueueDepth
  localparam int unsigned PtrWidth   = $clog2(QueueDepth);
  localparam int unsigned ThldWidth  = $clog2(QueueDepth);      // Thresholds stop at depth - 1
  localparam int unsigned NumQueues  = 4;

  // Register map, byte offsets
  localparam logic [AddrWidth-1:0] RegResetCtrl   = 5'h00;  // Bit per queue, self-clearing
  localparam logic [AddrWidth-1:0] RegQueueThld   = 5'h04;  // Cmd in 7:0, response in 15:8
  localparam logic [AddrWidth-1:0] RegDataThld    = 5'h08;  // RX in 2:0, TX in 10:8
  localparam logic [AddrWidth-1:0] RegCmdPort     = 5'h0C;
  localparam logic [AddrWidth-1:0] RegXferPort    = 5'h10;  // Write pushes TX, read pops RX
  localparam logic [AddrWidth-1:0] RegRespPort    = 5'h14;
  localparam logic [AddrWidth-1:0] RegQueueStatus = 5'h18;  // Empty in 3:0, threshold in 7:4

  // Queue index, also the bit order of reset control and status
  typedef enum logic [1:0] {
    QCmd  = 2'd0,
    QRx   = 2'd1,
    QTx   = 2'd2,
    QResp = 2'd3
  } queue_idx_e;

  // CPU request, held for a single cycle
  typedef struct packed {
    logic                 req;
    logic                 is_wr;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } cpu_req_t;

  // CPU response, exactly one cycle after the request
  typedef struct packed {
    logic                 rd_ack;
    logic                 wr_ack;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } cpu_rsp_t;

  // Head of the command or TX queue as seen by the controller
  typedef struct packed {
    logic                valid;
    logic [CmdWidth-1:0] data;
  } ctrl_pop_t;

  // RX data or response pushed by the controller
  typedef struct packed {
    logic                 push;
    logic [DataWidth-1:0] data;
  } ctrl_push_t;

endpackage

`default_nettype wire

// File: verilog/hci_queue.sv
/* HCI queue: synchronous circular FIFO with flush and occupancy level */
`timescale 1ns/1ps
`default_nettype none

module hci_queue
  import hci_pkg::*;
#(
  parameter int unsigned Width = DataWidth
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  logic [Width-1:0]      wdata_i,
  input  logic                  pop_i,
  output logic [Width-1:0]      rdata_o,
  output logic                  empty_o,
  output logic                  full_o,
  output logic [LevelWidth-1:0] level_o
);

  logic [Width-1:0]      mem_q [QueueDepth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [LevelWidth-1:0] level_q;
  logic                  do_push;
  logic                  do_pop;

  assign empty_o = (level_q == '0);
  assign full_o  = (level_q == LevelWidth'(QueueDepth));
  assign level_o = level_q;
  assign rdata_o = mem_q[rd_ptr_q];  // Head is visible without a pop

  // Overflow and underflow are silently ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else if (flush_i) begin
      // Flush wins over a push or pop in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Depth is a power of two, pointers wrap
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      level_q <= level_q + LevelWidth'(do_push) - LevelWidth'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // The producers are expected to watch full and empty themselves
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && !flush_i |-> !full_o)
    else $error("push into full queue");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i && !flush_i |-> !empty_o)
    else $error("pop from empty queue");

endmodule

`default_nettype wire

// File: verilog/hci_top.sv
/* HCI top: register block, command assembler and the four queues, with the
   controller side exported as plain strobes */
`timescale 1ns/1ps
`default_nettype none

module hci_top
  import hci_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  cpu_req_t   cpu_req_i,
  output cpu_rsp_t   cpu_rsp_o,
  input  logic       cmd_pop_i,
  output ctrl_pop_t  cmd_o,
  input  logic       tx_pop_i,
  output ctrl_pop_t  tx_o,
  input  ctrl_push_t rx_i,
  output logic       rx_full_o,
  input  ctrl_push_t resp_i,
  output logic       resp_full_o
);

  logic [NumQueues-1:0]                 q_empty;
  logic [NumQueues-1:0]                 q_full;
  logic [NumQueues-1:0][LevelWidth-1:0] q_level;
  logic [NumQueues-1:0][CmdWidth-1:0]   q_head;
  logic [NumQueues-1:0]                 q_flush;
  logic [NumQueues-1:0]                 q_push;
  logic [NumQueues-1:0]                 q_pop;
  logic [NumQueues-1:0][CmdWidth-1:0]   q_wdata;
  logic [NumQueues-1:0]                 csr_push;
  logic [NumQueues-1:0][DataWidth-1:0]  csr_wdata;
  logic [NumQueues-1:0]                 csr_pop;
  logic                                 cmd_dword;
  logic [DataWidth-1:0]                 cmd_dword_data;
  logic                                 asm_push;
  logic [CmdWidth-1:0]                  asm_cmd;

  hci_csr u_csr (
    .clk_i,
    .rst_ni,
    .cpu_req_i,
    .cpu_rsp_o,
    .q_empty_i        (q_empty),
    .q_full_i         (q_full),
    .q_level_i        (q_level),
    .q_head_i         (q_head),
    .q_push_o         (csr_push),
    .q_wdata_o        (csr_wdata),
    .q_pop_o          (csr_pop),
    .q_flush_o        (q_flush),
    .cmd_dword_o      (cmd_dword),
    .cmd_dword_data_o (cmd_dword_data),
    .cmd_full_i       (q_full[QCmd])
  );

  hci_cmd_assembler u_cmd_asm (
    .clk_i,
    .rst_ni,
    .flush_i      (q_flush[QCmd]),  // Command reset also drops a half command
    .dword_i      (cmd_dword),
    .dword_data_i (cmd_dword_data),
    .push_o       (asm_push),
    .cmd_o        (asm_cmd)
  );

  // Push sources
  assign q_push[QCmd]   = asm_push;
  assign q_push[QRx]    = rx_i.push;
  assign q_push[QTx]    = csr_push[QTx];
  assign q_push[QResp]  = resp_i.push;
  assign q_wdata[QCmd]  = asm_cmd;
  assign q_wdata[QRx]   = CmdWidth'(rx_i.data);
  assign q_wdata[QTx]   = CmdWidth'(csr_wdata[QTx]);
  assign q_wdata[QResp] = CmdWidth'(resp_i.data);

  // Pop sources
  assign q_pop[QCmd]  = cmd_pop_i;
  assign q_pop[QRx]   = csr_pop[QRx];
  assign q_pop[QTx]   = tx_pop_i;
  assign q_pop[QResp] = csr_pop[QResp];

  for (genvar i = 0; i < NumQueues; i++) begin : g_queue
    localparam int unsigned QWidth = (i == int'(QCmd)) ? CmdWidth : DataWidth;

    logic [QWidth-1:0] head;

    hci_queue #(
      .Width (QWidth)
    ) u_queue (
      .clk_i,
      .rst_ni,
      .flush_i (q_flush[i]),
      .push_i  (q_push[i]),
      .wdata_i (q_wdata[i][QWidth-1:0]),
      .pop_i   (q_pop[i]),
      .rdata_o (head),
      .empty_o (q_empty[i]),
      .full_o  (q_full[i]),
      .level_o (q_level[i])
    );

    assign q_head[i] = CmdWidth'(head);  // Data queues zero-extended
  end

  assign cmd_o.valid = ~q_empty[QCmd];
  assign cmd_o.data  = q_head[QCmd];
  assign tx_o.valid  = ~q_empty[QTx];
  assign tx_o.data   = q_head[QTx];
  assign rx_full_o   = q_full[QRx];
  assign resp_full_o = q_full[QResp];

endmodule

`default_nettype wire
